// File: flist.f
+incdir+dv
src/rv_pkg.sv
src/rv_decode.sv
src/rv_regfile.sv
src/rv_alu.sv
src/rv_branch_unit.sv
src/rv_lsu.sv
src/rv_memory.sv
src/rv_top.sv
dv/tb_top.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the testbench, exit status carries the result
cd "$(dirname "$0")" \
    && verilator --binary --timing --timescale 1ns/1ps --top-module tb_top \
        -f flist.f -o tb_sim \
    && ./obj_dir/tb_sim \
    || exit 1

// File: dv/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

logic [31:0] lfsr_state;
logic [31:0] prog [$];                                       // program image, one word per entry
logic [7:0]  model_mem [MEM_BYTES];
uart_tx_t    exp_q [$];                                      // predicted transmit strobes

////////////////////
// random source
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};           // taps 32 22 2 1
endfunction

function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_step(lfsr_state);
        v = {v[30:0], lfsr_state[0]};
    end
    return v;
endfunction

function automatic logic [4:0] rand_reg();
    return 5'(1 + rand_bits(5) % 30);                        // x1..x30
endfunction

////////////////////
// instruction encoders
function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                      input logic [6:0] opc);
    return {imm, rd, opc};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
endfunction

// executed only if a jump or taken branch fails to skip it
function automatic logic [31:0] poison();
    logic [4:0] r;
    r = rand_reg();
    return enc_i(12'h5a5, r, F3_XOR, r, OPC_OP_IMM);
endfunction

////////////////////
// program generator
task automatic build_program();
    logic [2:0]  kind;
    logic [3:0]  sel;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [10:0] off;
    logic [4:0]  rd;
    logic [4:0]  ra;
    logic [4:0]  rb;
    prog.delete();
    prog.push_back(enc_u(UART_TX_ADDR[31:12] + 20'(UART_TX_ADDR[11]), 5'd31, OPC_LUI));
    prog.push_back(enc_i(UART_TX_ADDR[11:0], 5'd31, F3_ADD, 5'd31, OPC_OP_IMM));
    for (int r = 1; r <= 30; r++) begin
        prog.push_back(enc_u(20'(rand_bits(20)), 5'(r), OPC_LUI));
        prog.push_back(enc_i(12'(rand_bits(12)), 5'(r), F3_ADD, 5'(r), OPC_OP_IMM));
    end
    for (int n = 0; n < 160; n++) begin
        kind = 3'(rand_bits(3));
        rd   = rand_reg();
        ra   = rand_reg();
        rb   = rand_reg();
        case (kind)
            3'd0, 3'd1: begin
                sel = 4'(rand_bits(4) % 10);
                if (sel < 4'd8) begin
                    prog.push_back(enc_r(F7_BASE, rb, ra, sel[2:0], rd));
                end else begin
                    f3 = (sel == 4'd8) ? F3_ADD : F3_SR;     // sub or sra
                    prog.push_back(enc_r(F7_ALT, rb, ra, f3, rd));
                end
            end
            3'd2: begin
                sel = 4'(rand_bits(4) % 9);
                f3  = (sel == 4'd8) ? F3_SR : sel[2:0];
                imm = 12'(rand_bits(12));
                if (sel == 4'd8) begin
                    imm = {F7_ALT, imm[4:0]};                // srai
                end else if (f3 == F3_SLL || f3 == F3_SR) begin
                    imm = {F7_BASE, imm[4:0]};
                end
                prog.push_back(enc_i(imm, ra, f3, rd, OPC_OP_IMM));
            end
            3'd3: begin
                prog.push_back(enc_u(20'(rand_bits(20)), rd,
                                     (rand_bits(1) != 0) ? OPC_LUI : OPC_AUIPC));
            end
            3'd4: begin
                sel = 4'(rand_bits(4) % 6);
                f3  = (sel < 4'd2) ? sel[2:0] : 3'(sel + 4'd2);
                if (rand_bits(1) != 0) begin
                    rb = ra;                                 // equal operands now and then
                end
                prog.push_back(enc_b(13'd8, rb, ra, f3));
                prog.push_back(poison());
            end
            3'd5: begin
                prog.push_back(enc_j(21'd8, rd));
                prog.push_back(poison());
            end
            3'd6: begin
                prog.push_back(enc_u(20'd0, ra, OPC_AUIPC));
                prog.push_back(enc_i(12'd13, ra, F3_ADD, rd, OPC_JALR));   // odd offset
                prog.push_back(poison());
            end
            default: begin
                off = {9'(rand_bits(9)), 2'b00};
                prog.push_back(enc_u(20'h4, ra, OPC_LUI));              // data area at 0x4000
                prog.push_back(enc_s({1'b0, off}, rb, ra, F3_MEM_W));
                prog.push_back(enc_s({1'b0, off[10:2], 2'(rand_bits(2))}, rd, ra, F3_MEM_B));
                prog.push_back(enc_i({1'b0, off}, ra, F3_MEM_W, rd, OPC_LOAD));
                prog.push_back(enc_s(12'd0, rb, 5'd31, F3_MEM_B));
                // word that the transmit address aliases to in memory
                prog.push_back(enc_i(12'(UART_TX_ADDR[MEM_AW-1:0]), 5'd0, F3_MEM_W, rb,
                                     OPC_LOAD));
            end
        endcase
    end
    // register dump, x30 first so it can serve as scratch afterwards
    for (int r = 30; r >= 1; r--) begin
        prog.push_back(enc_s(12'd0, 5'(r), 5'd31, F3_MEM_B));
        for (int k = 1; k < 4; k++) begin
            if (r == 30) begin
                prog.push_back(enc_i(12'd8, 5'd30, F3_SR, 5'd30, OPC_OP_IMM));
            end else begin
                prog.push_back(enc_i(12'(8 * k), 5'(r), F3_SR, 5'd30, OPC_OP_IMM));
            end
            prog.push_back(enc_s(12'd0, 5'd30, 5'd31, F3_MEM_B));
        end
    end
    prog.push_back(enc_j(21'd0, 5'd0));                      // park on a self loop
endtask

////////////////////
// reference model
function automatic logic [31:0] mem_read_word(input logic [31:0] addr);
    logic [31:0] w;
    for (int k = 0; k < 4; k++) begin
        w[8*k +: 8] = model_mem[MEM_AW'(addr + 32'(k))];
    end
    return w;
endfunction

function automatic void mem_write_byte(input logic [31:0] addr, input logic [7:0] data);
    model_mem[MEM_AW'(addr)] = data;                         // wraps at memory size
endfunction

function automatic void mem_write_word(input logic [31:0] addr, input logic [31:0] data);
    for (int k = 0; k < 4; k++) begin
        mem_write_byte(addr + 32'(k), data[8*k +: 8]);
    end
endfunction

function automatic logic [31:0] model_alu(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
        F3_ADD: begin
            if (alt) begin
                return a - b;
            end
            return a + b;
        end
        F3_SLL:  return a << b[4:0];
        F3_SLT:  return {31'b0, $signed(a) < $signed(b)};
        F3_SLTU: return {31'b0, a < b};
        F3_XOR:  return a ^ b;
        F3_SR: begin
            if (alt) begin
                return 32'($signed(a) >>> b[4:0]);
            end
            return a >> b[4:0];
        end
        F3_OR:   return a | b;
        default: return a & b;
    endcase
endfunction

task automatic run_model();
    logic [31:0] x [32];
    logic [31:0] pc;
    logic [31:0] inst;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] addr;
    logic [31:0] next;
    logic [31:0] wb;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [2:0]  f3;
    logic        wb_en;
    logic        taken;
    uart_tx_t    tx;
    int          steps;
    for (int i = 0; i < 32; i++) begin
        x[i] = '0;
    end
    for (int i = 0; i < prog.size(); i++) begin
        mem_write_word(32'(4 * i), prog[i]);
    end
    exp_q.delete();
    pc    = '0;
    steps = 0;
    while (pc != 32'(4 * (prog.size() - 1))) begin
        steps++;
        if (steps > 100000) begin
            fail_run("reference model did not reach the end of the program");
        end
        inst  = mem_read_word(pc);
        f3    = inst[14:12];
        a     = x[inst[19:15]];
        b     = x[inst[24:20]];
        imm_i = {{20{inst[31]}}, inst[31:20]};
        imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        next  = pc + 4;
        wb    = pc + 4;                                      // link value
        wb_en = 1'b1;
        case (inst[6:0])
            OPC_OP:     wb = model_alu(f3, inst[30], a, b);
            OPC_OP_IMM: wb = model_alu(f3, f3 == F3_SR && inst[30], a, imm_i);
            OPC_LUI:    wb = {inst[31:12], 12'h000};
            OPC_AUIPC:  wb = pc + {inst[31:12], 12'h000};
            OPC_JAL:    next = pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            OPC_JALR:   next = (a + imm_i) & ~32'd1;
            OPC_LOAD:   wb = mem_read_word((a + imm_i) & ~32'd3);
            OPC_BRANCH: begin
                wb_en = 1'b0;
                case (f3)
                    F3_BEQ:  taken = (a == b);
                    F3_BNE:  taken = (a != b);
                    F3_BLT:  taken = ($signed(a) < $signed(b));
                    F3_BGE:  taken = ($signed(a) >= $signed(b));
                    F3_BLTU: taken = (a < b);
                    default: taken = (a >= b);               // bgeu
                endcase
                if (taken) begin
                    next = pc + imm_b;
                end
            end
            OPC_STORE: begin
                wb_en = 1'b0;
                addr  = a + imm_s;
                if (f3 == F3_MEM_W) begin
                    mem_write_word(addr & ~32'd3, b);
                end else if (addr == UART_TX_ADDR) begin
                    tx.en   = 1'b1;
                    tx.data = b[7:0];
                    exp_q.push_back(tx);
                end else begin
                    mem_write_byte(addr, b[7:0]);
                end
            end
            default: fail_run("reference model met an instruction it does not know");
        endcase
        if (wb_en && inst[11:7] != 5'd0) begin
            x[inst[11:7]] = wb;
        end
        pc = next;
    end
endtask

`endif

// File: dv/tb_top.sv
`timescale 1ns/1ps

module tb_top;
    import rv_pkg::*;

    localparam int STROBE_TIMEOUT = 4096;                    // cycles allowed between strobes
    localparam int DRAIN_CYCLES   = 50;

    logic       clk;
    logic       reset;
    load_port_t load_port;
    uart_tx_t   uart;

    `include "tb_model.svh"

    rv_top i_dut (
        .clk    (clk),
        .reset  (reset),
        .i_load (load_port),
        .o_uart (uart)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;                                   // 8 ns period
        end
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic compare_uart(input uart_tx_t got, input uart_tx_t exp_val);
        if (got !== exp_val) begin
            fail_run($sformatf("ERROR at %0t: o_uart got en=%b data=%02h, expected en=%b data=%02h",
                               $time, got.en, got.data, exp_val.en, exp_val.data));
        end
    endtask

    task automatic check_quiet();
        if (uart.en !== 1'b0) begin
            fail_run("transmit strobe was not low during reset and program load");
        end
    endtask

    ////////////////////
    // strobe waits, sampled mid cycle
    task automatic wait_for_strobe(input int n, output uart_tx_t got);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (uart.en !== 1'b1) begin
            if (uart.en !== 1'b0) begin
                fail_run("transmit strobe went unknown");
            end
            cycles++;
            if (cycles > STROBE_TIMEOUT) begin
                fail_run($sformatf("timed out waiting for transmit strobe %0d of %0d",
                                   n + 1, exp_q.size()));
            end
            @(negedge clk);
        end
        got = uart;
    endtask

    task automatic check_drain();
        for (int c = 0; c < DRAIN_CYCLES; c++) begin
            @(negedge clk);
            if (uart.en !== 1'b0) begin
                fail_run("extra transmit strobe after the last expected one");
            end
        end
    endtask

    initial begin
        uart_tx_t got;
        reset      = 1'b1;
        load_port  = '0;
        lfsr_state = 32'h5e31_3f40;
        build_program();
        run_model();
        $display("program of %0d words, %0d strobes expected", prog.size(), exp_q.size());

        // program goes in while the core is held in reset
        for (int i = 0; i < prog.size(); i++) begin
            @(negedge clk);
            check_quiet();
            load_port.en   = 1'b1;
            load_port.addr = LOAD_AW'(i);
            load_port.data = prog[i];
        end
        @(negedge clk);
        load_port = '0;
        repeat (3) begin
            @(negedge clk);
            check_quiet();
        end
        reset = 1'b0;

        for (int n = 0; n < exp_q.size(); n++) begin
            wait_for_strobe(n, got);
            compare_uart(got, exp_q[n]);
        end
        check_drain();
        $display("** PASS **");
        $finish;
    end

endmodule

// File: src/rv_top.sv
`timescale 1ns/1ps

module rv_top (
    input  logic               clk,
    input  logic               reset,
    input  rv_pkg::load_port_t i_load,
    output rv_pkg::uart_tx_t   o_uart
);
    import rv_pkg::*;

    logic [XLEN-1:0] inst;
    logic [XLEN-1:0] pc;
    decoded_t        dec;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] alu_result;                             // also the effective address
    logic [XLEN-1:0] wb_data;
    logic [XLEN-1:0] load_data;
    mem_req_t        req;

    rv_decode u_decode (
        .i_inst (inst),
        .o_dec  (dec)
    );

    rv_regfile u_regfile (
        .clk        (clk),
        .reset      (reset),
        .i_dec      (dec),
        .i_wb_data  (wb_data),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    rv_alu u_alu (
        .i_dec      (dec),
        .i_pc       (pc),
        .i_rs1_data (rs1_data),
        .i_rs2_data (rs2_data),
        .o_result   (alu_result)
    );

    rv_branch_unit u_branch (
        .clk        (clk),
        .reset      (reset),
        .i_dec      (dec),
        .i_rs1_data (rs1_data),
        .i_rs2_data (rs2_data),
        .o_pc       (pc)
    );

    rv_lsu u_lsu (
        .reset        (reset),
        .i_dec        (dec),
        .i_addr       (alu_result),
        .i_rs2_data   (rs2_data),
        .i_alu_result (alu_result),
        .i_load_data  (load_data),
        .o_req        (req),
        .o_wb_data    (wb_data),
        .o_uart       (o_uart)
    );

    rv_memory u_memory (
        .clk         (clk),
        .reset       (reset),
        .i_pc        (pc),
        .i_req       (req),
        .i_load      (i_load),
        .o_inst      (inst),
        .o_load_data (load_data)
    );

endmodule

// File: src/rv_memory.sv
`timescale 1ns/1ps

module rv_memory (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [rv_pkg::XLEN-1:0] i_pc,
    input  rv_pkg::mem_req_t        i_req,
    input  rv_pkg::load_port_t      i_load,
    output logic [rv_pkg::XLEN-1:0] o_inst,
    output logic [rv_pkg::XLEN-1:0] o_load_data
);
    import rv_pkg::*;

    logic [7:0]        mem [MEM_BYTES];
    logic [MEM_AW-1:0] st_base;

    // little endian, wraps at the top of memory
    function automatic logic [XLEN-1:0] read_word(input logic [MEM_AW-1:0] a);
        return {mem[a + MEM_AW'(3)], mem[a + MEM_AW'(2)], mem[a + MEM_AW'(1)], mem[a]};
    endfunction

    assign o_inst      = read_word(i_pc[MEM_AW-1:0]);
    assign o_load_data = i_req.load ? read_word(i_req.addr[MEM_AW-1:0]) : '0;

    assign st_base = {i_req.addr[MEM_AW-1:2], 2'b00};

    ////////////////////
    // write path, load port wins
    always_ff @(posedge clk) begin
        if (i_load.en) begin
            for (int k = 0; k < 4; k++) begin
                mem[{i_load.addr, 2'(k)}] <= i_load.data[8*k +: 8];
            end
        end else if (!reset) begin
            for (int k = 0; k < 4; k++) begin
                if (i_req.strb[k]) begin
                    mem[st_base + MEM_AW'(k)] <= i_req.wdata[8*k +: 8];   // lane k
                end
            end
        end
    end

endmodule

// File: src/rv_lsu.sv
`timescale 1ns/1ps

module rv_lsu (
    input  logic                    reset,
    input  rv_pkg::decoded_t        i_dec,
    input  logic [rv_pkg::XLEN-1:0] i_addr,
    input  logic [rv_pkg::XLEN-1:0] i_rs2_data,
    input  logic [rv_pkg::XLEN-1:0] i_alu_result,
    input  logic [rv_pkg::XLEN-1:0] i_load_data,
    output rv_pkg::mem_req_t        o_req,
    output logic [rv_pkg::XLEN-1:0] o_wb_data,
    output rv_pkg::uart_tx_t        o_uart
);
    import rv_pkg::*;

    logic is_uart;

    assign is_uart = i_dec.is_store_byte && (i_addr == UART_TX_ADDR);

    always_comb begin
        o_req       = '0;
        o_req.load  = i_dec.is_load;
        o_req.addr  = {i_addr[XLEN-1:2], 2'b00};             // word aligned
        o_req.wdata = i_rs2_data;
        if (i_dec.is_store_word) begin
            o_req.strb = 4'b1111;
        end else if (i_dec.is_store_byte && !is_uart) begin
            o_req.addr  = i_addr;
            o_req.wdata = {4{i_rs2_data[7:0]}};              // byte on every lane
            o_req.strb  = 4'b0001 << i_addr[1:0];
        end
    end

    assign o_wb_data   = i_dec.is_load ? i_load_data : i_alu_result;

    assign o_uart.en   = is_uart && !reset;
    assign o_uart.data = i_rs2_data[7:0];

endmodule

// File: src/rv_branch_unit.sv
`timescale 1ns/1ps

module rv_branch_unit (
    input  logic                    clk,
    input  logic                    reset,
    input  rv_pkg::decoded_t        i_dec,
    input  logic [rv_pkg::XLEN-1:0] i_rs1_data,
    input  logic [rv_pkg::XLEN-1:0] i_rs2_data,
    output logic [rv_pkg::XLEN-1:0] o_pc
);
    import rv_pkg::*;

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] next_pc;
    logic [XLEN-1:0] pc_target;
    logic [XLEN-1:0] jalr_target;
    logic            take;

    assign pc_target   = pc + i_dec.imm;
    assign jalr_target = (i_rs1_data + i_dec.imm) & ~32'd1;

    always_comb begin
        case (i_dec.branch_op)
            BR_BEQ:  take = (i_rs1_data == i_rs2_data);
            BR_BNE:  take = (i_rs1_data != i_rs2_data);
            BR_BLT:  take = ($signed(i_rs1_data) <  $signed(i_rs2_data));
            BR_BGE:  take = ($signed(i_rs1_data) >= $signed(i_rs2_data));
            BR_BLTU: take = (i_rs1_data <  i_rs2_data);
            BR_BGEU: take = (i_rs1_data >= i_rs2_data);
            BR_JAL:  take = 1'b1;
            default: take = 1'b0;                            // none, jalr handled below
        endcase
    end

    assign next_pc = (i_dec.branch_op == BR_JALR) ? jalr_target :
                     take                         ? pc_target   : pc + 32'd4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= next_pc;
        end
    end

    assign o_pc = pc;

endmodule

// File: src/rv_alu.sv
`timescale 1ns/1ps

module rv_alu (
    input  rv_pkg::decoded_t        i_dec,
    input  logic [rv_pkg::XLEN-1:0] i_pc,
    input  logic [rv_pkg::XLEN-1:0] i_rs1_data,
    input  logic [rv_pkg::XLEN-1:0] i_rs2_data,
    output logic [rv_pkg::XLEN-1:0] o_result
);
    import rv_pkg::*;

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [4:0]      shamt;

    assign op_a  = i_dec.op_a_pc  ? i_pc      : i_rs1_data;
    assign op_b  = i_dec.op_b_imm ? i_dec.imm : i_rs2_data;
    assign shamt = op_b[4:0];                                // imm or rs2 low bits

    always_comb begin
        case (i_dec.alu_op)
            ALU_ADD:    o_result = op_a + op_b;
            ALU_SUB:    o_result = op_a - op_b;
            ALU_AND:    o_result = op_a & op_b;
            ALU_OR:     o_result = op_a | op_b;
            ALU_XOR:    o_result = op_a ^ op_b;
            ALU_SLL:    o_result = op_a << shamt;
            ALU_SRL:    o_result = op_a >> shamt;
            ALU_SRA:    o_result = $signed(op_a) >>> shamt;
            ALU_SLT:    o_result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   o_result = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_PASS_B: o_result = op_b;                     // lui
            ALU_LINK:   o_result = i_pc + 32'd4;             // return address
            default:    o_result = '0;
        endcase
    end

endmodule

// File: src/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
    input  logic                    clk,
    input  logic                    reset,
    input  rv_pkg::decoded_t        i_dec,
    input  logic [rv_pkg::XLEN-1:0] i_wb_data,
    output logic [rv_pkg::XLEN-1:0] o_rs1_data,
    output logic [rv_pkg::XLEN-1:0] o_rs2_data
);
    import rv_pkg::*;

    logic [XLEN-1:0] regs [1:REG_COUNT-1];                  // x0 has no storage

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (i_dec.reg_write && i_dec.rd != '0) begin
            regs[i_dec.rd] <= i_wb_data;
        end
    end

    assign o_rs1_data = (i_dec.rs1 == '0) ? '0 : regs[i_dec.rs1];
    assign o_rs2_data = (i_dec.rs2 == '0) ? '0 : regs[i_dec.rs2];

endmodule

// File: src/rv_decode.sv
`timescale 1ns/1ps

module rv_decode (
    input  logic [rv_pkg::XLEN-1:0] i_inst,
    output rv_pkg::decoded_t        o_dec
);
    import rv_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;

    assign opcode = i_inst[6:0];
    assign funct3 = i_inst[14:12];
    assign funct7 = i_inst[31:25];

    ////////////////////
    // immediate formats
    assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
    assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
    assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
    assign imm_u = {i_inst[31:12], 12'h000};
    assign imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            F3_ADD:  return alt ? ALU_SUB : ALU_ADD;
            F3_SLL:  return ALU_SLL;
            F3_SLT:  return ALU_SLT;
            F3_SLTU: return ALU_SLTU;
            F3_XOR:  return ALU_XOR;
            F3_SR:   return alt ? ALU_SRA : ALU_SRL;
            F3_OR:   return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    always_comb begin
        o_dec           = '0;                                // nop unless decoded below
        o_dec.rd        = i_inst[11:7];
        o_dec.rs1       = i_inst[19:15];
        o_dec.rs2       = i_inst[24:20];
        o_dec.alu_op    = ALU_ADD;
        o_dec.branch_op = BR_NONE;
        o_dec.imm       = imm_i;
        case (opcode)
            OPC_OP: begin
                o_dec.alu_op    = arith_op(funct3, funct7 == F7_ALT);
                o_dec.reg_write = (funct7 == F7_BASE) ||
                                  (funct7 == F7_ALT && (funct3 == F3_ADD || funct3 == F3_SR));
            end
            OPC_OP_IMM: begin
                o_dec.op_b_imm  = 1'b1;
                o_dec.alu_op    = arith_op(funct3, funct3 == F3_SR && funct7 == F7_ALT);
                o_dec.reg_write = (funct3 == F3_SLL) ? (funct7 == F7_BASE) :
                                  (funct3 == F3_SR)  ? (funct7 == F7_BASE || funct7 == F7_ALT) :
                                  1'b1;
            end
            OPC_LOAD: begin
                o_dec.op_b_imm  = 1'b1;                      // rs1 + offset
                o_dec.is_load   = (funct3 == F3_MEM_W);
                o_dec.reg_write = (funct3 == F3_MEM_W);
            end
            OPC_STORE: begin
                o_dec.op_b_imm      = 1'b1;
                o_dec.imm           = imm_s;
                o_dec.is_store_word = (funct3 == F3_MEM_W);
                o_dec.is_store_byte = (funct3 == F3_MEM_B);
            end
            OPC_BRANCH: begin
                o_dec.imm = imm_b;
                case (funct3)
                    F3_BEQ:  o_dec.branch_op = BR_BEQ;
                    F3_BNE:  o_dec.branch_op = BR_BNE;
                    F3_BLT:  o_dec.branch_op = BR_BLT;
                    F3_BGE:  o_dec.branch_op = BR_BGE;
                    F3_BLTU: o_dec.branch_op = BR_BLTU;
                    F3_BGEU: o_dec.branch_op = BR_BGEU;
                    default: o_dec.branch_op = BR_NONE;
                endcase
            end
            OPC_JAL: begin
                o_dec.imm       = imm_j;
                o_dec.alu_op    = ALU_LINK;
                o_dec.branch_op = BR_JAL;
                o_dec.reg_write = 1'b1;
            end
            OPC_JALR: begin
                if (funct3 == F3_ADD) begin
                    o_dec.alu_op    = ALU_LINK;
                    o_dec.branch_op = BR_JALR;
                    o_dec.reg_write = 1'b1;
                end
            end
            OPC_LUI: begin
                o_dec.imm       = imm_u;
                o_dec.op_b_imm  = 1'b1;
                o_dec.alu_op    = ALU_PASS_B;
                o_dec.reg_write = 1'b1;
            end
            OPC_AUIPC: begin
                o_dec.imm       = imm_u;
                o_dec.op_b_imm  = 1'b1;
                o_dec.op_a_pc   = 1'b1;                      // pc + upper imm
                o_dec.reg_write = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// File: src/rv_pkg.sv
package rv_pkg;

    ////////////////////
    // sizes
    localparam int XLEN      = 32;
    localparam int REG_COUNT = 32;
    localparam int REG_AW    = $clog2(REG_COUNT);
    localparam int MEM_BYTES = 32768;
    localparam int MEM_AW    = $clog2(MEM_BYTES);            // byte address bits
    localparam int LOAD_AW   = MEM_AW - 2;                   // word address bits

    localparam logic [XLEN-1:0] UART_TX_ADDR = 32'h0002_0020;

    ////////////////////
    // opcodes and function codes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    localparam logic [2:0] F3_ADD  = 3'b000;                 // add, sub, addi, jalr
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;                 // srl and sra
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [2:0] F3_MEM_B = 3'b000;                // sb
    localparam logic [2:0] F3_MEM_W = 3'b010;                // lw, sw

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;             // sub, sra, srai

    ////////////////////
    // types
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_SLT, ALU_SLTU, ALU_PASS_B, ALU_LINK
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU, BR_JAL, BR_JALR
    } branch_op_e;

    typedef struct packed {
        logic [REG_AW-1:0] rd;
        logic [REG_AW-1:0] rs1;
        logic [REG_AW-1:0] rs2;
        alu_op_e           alu_op;
        branch_op_e        branch_op;
        logic              op_b_imm;
        logic              op_a_pc;
        logic              reg_write;
        logic              is_load;
        logic              is_store_word;
        logic              is_store_byte;
        logic [XLEN-1:0]   imm;
    } decoded_t;

    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
        logic [3:0]      strb;
        logic            load;
    } mem_req_t;

    typedef struct packed {
        logic               en;
        logic [LOAD_AW-1:0] addr;
        logic [XLEN-1:0]    data;
        logic [1:0]         pad;
    } load_port_t;

    typedef struct packed {
        logic       en;
        logic [7:0] data;
    } uart_tx_t;

endpackage
